/* rtl/stat_pkg.sv */
package stat_pkg;

    // number of event channels feeding the block
    localparam int NUM_CHAN = 4;

    // width of one accumulated total in the count memory
    localparam int COUNT_W = 32;

    // window length in aclk cycles
    localparam int FLUSH_PERIOD = 7;

    // narrow counter width, holds the FLUSH_PERIOD events of one window
    localparam int CHUNK_W = 3;

    // width of a channel index
    localparam int CHAN_W = 2;

    // requesters on the count memory: the channels plus the host read port
    localparam int NUM_SRC = NUM_CHAN + 1;

    // flush timer width, counts FLUSH_PERIOD-1 down to 0
    localparam int TIMER_W = $clog2(FLUSH_PERIOD);

    // memory requesters, also the round-robin pointer value
    typedef enum logic [2:0] {
        SRC_CH0  = 3'd0,
        SRC_CH1  = 3'd1,
        SRC_CH2  = 3'd2,
        SRC_CH3  = 3'd3,
        SRC_HOST = 3'd4
    } src_e;

    // what the count memory does in a given cycle
    typedef enum logic [1:0] {
        OP_IDLE  = 2'd0,
        OP_ACCUM = 2'd1,
        OP_READ  = 2'd2
    } ram_op_e;

endpackage

/* rtl/flush_timer.sv */
`timescale 1ns/1ps

module flush_timer (
    input  logic aclk,
    input  logic rst_i,
    output logic flush_tick_o
);

    // down-counter, one tick per FLUSH_PERIOD cycles
    logic [stat_pkg::TIMER_W-1:0] tick_cnt;

    // reload value for a full window
    localparam logic [stat_pkg::TIMER_W-1:0] RELOAD =
        stat_pkg::TIMER_W'(stat_pkg::FLUSH_PERIOD - 1);

    always_ff @(posedge aclk) begin
        if (rst_i) begin
            // first tick lands FLUSH_PERIOD cycles after release
            tick_cnt <= RELOAD;
        end else if (tick_cnt == '0) begin
            tick_cnt <= RELOAD;
        end else begin
            tick_cnt <= tick_cnt - 1'b1;
        end
    end

    // tick on the terminal count
    // every channel sees the same tick so all windows close together
    assign flush_tick_o = (tick_cnt == '0);

endmodule

/* rtl/event_chunk_counter.sv */
`timescale 1ns/1ps

module event_chunk_counter (
    input  logic                         aclk,
    input  logic                         rst_i,
    input  logic                         event_i,
    input  logic                         flush_tick_i,
    output logic                         req_o,
    input  logic                         grant_i,
    output logic [stat_pkg::CHUNK_W-1:0] chunk_o
);

    // running count for the current window
    logic [stat_pkg::CHUNK_W-1:0] active_cnt;
    // parked count of the last closed window
    logic [stat_pkg::CHUNK_W-1:0] hold_cnt;
    // request level towards the arbiter
    logic                         req;

    always_ff @(posedge aclk) begin
        if (rst_i) begin
            active_cnt <= '0;
        end else if (flush_tick_i) begin
            // the tick-cycle event already belongs to the new window
            active_cnt <= stat_pkg::CHUNK_W'(event_i);
        end else begin
            active_cnt <= active_cnt + stat_pkg::CHUNK_W'(event_i);
        end
    end

    // hold register only changes on a tick
    // it stays stable while the request waits for its grant
    always_ff @(posedge aclk) begin
        if (flush_tick_i) begin
            hold_cnt <= active_cnt;
        end
    end

    always_ff @(posedge aclk) begin
        if (rst_i) begin
            req <= 1'b0;
        end else if (flush_tick_i) begin
            // request rises the cycle after the tick
            req <= 1'b1;
        end else if (grant_i) begin
            // falls the cycle after the grant pulse
            req <= 1'b0;
        end
    end

    assign req_o   = req;
    assign chunk_o = hold_cnt;

    // arbiter must drain the hold register inside one window
    // otherwise the next tick overwrites a chunk not yet added
    a_no_tick_while_pending: assert property (
        @(posedge aclk) disable iff (rst_i)
        flush_tick_i |-> !req
    ) else $error("flush tick while chunk request still pending");

    // a window never holds more events than the narrow counter can count
    a_no_active_overflow: assert property (
        @(posedge aclk) disable iff (rst_i)
        (event_i && !flush_tick_i) |-> (active_cnt != {stat_pkg::CHUNK_W{1'b1}})
    ) else $error("active chunk counter overflow");

endmodule

/* rtl/stat_arbiter.sv */
`timescale 1ns/1ps

module stat_arbiter (
    input  logic                                             aclk,
    input  logic                                             rst_i,
    input  logic [stat_pkg::NUM_CHAN-1:0]                    ch_req_i,
    input  logic [stat_pkg::NUM_CHAN-1:0][stat_pkg::CHUNK_W-1:0] ch_chunk_i,
    output logic [stat_pkg::NUM_CHAN-1:0]                    ch_grant_o,
    input  logic                                             rd_req_i,
    input  logic [stat_pkg::CHAN_W-1:0]                      rd_chan_i,
    output stat_pkg::ram_op_e                                op_o,
    output logic [stat_pkg::CHAN_W-1:0]                      chan_o,
    output logic [stat_pkg::CHUNK_W-1:0]                     chunk_o
);

    // last granted source, search starts just after it
    stat_pkg::src_e                      rr_ptr;
    // host read waiting for its slot
    logic                                host_pend;
    logic [stat_pkg::CHAN_W-1:0]         host_chan;

    // all requesters, host on the top bit to match SRC_HOST
    logic [stat_pkg::NUM_SRC-1:0]        req_vec;
    logic [stat_pkg::NUM_SRC-1:0]        gnt_vec;
    logic                                gnt_any;
    stat_pkg::src_e                      gnt_src;
    logic [stat_pkg::CHAN_W-1:0]         gnt_chan;

    assign req_vec = {host_pend, ch_req_i};

    // round-robin pick, at most one grant per cycle
    always_comb begin : pick
        int idx;
        gnt_vec = '0;
        gnt_any = 1'b0;
        gnt_src = rr_ptr;
        for (int k = 1; k <= stat_pkg::NUM_SRC; k++) begin
            idx = (int'(rr_ptr) + k) % stat_pkg::NUM_SRC;
            if (!gnt_any && req_vec[idx]) begin
                gnt_any      = 1'b1;
                gnt_vec[idx] = 1'b1;
                gnt_src      = stat_pkg::src_e'(idx);
            end
        end
    end

    // channel part of the source id, only meaningful for SRC_CH*
    assign gnt_chan   = gnt_src[stat_pkg::CHAN_W-1:0];
    assign ch_grant_o = gnt_vec[stat_pkg::NUM_CHAN-1:0];

    // memory command follows the grant in the same cycle
    always_comb begin
        op_o    = stat_pkg::OP_IDLE;
        chan_o  = '0;
        chunk_o = '0;
        if (gnt_any) begin
            if (gnt_src == stat_pkg::SRC_HOST) begin
                op_o   = stat_pkg::OP_READ;
                chan_o = host_chan;
            end else begin
                op_o    = stat_pkg::OP_ACCUM;
                chan_o  = gnt_chan;
                chunk_o = ch_chunk_i[gnt_chan];
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (rst_i) begin
            // CH0 gets first look after reset
            rr_ptr <= stat_pkg::SRC_HOST;
        end else if (gnt_any) begin
            rr_ptr <= gnt_src;
        end
    end

    // pending host read latch
    always_ff @(posedge aclk) begin
        if (rst_i) begin
            host_pend <= 1'b0;
        end else if (rd_req_i) begin
            host_pend <= 1'b1;
        end else if (gnt_vec[stat_pkg::SRC_HOST]) begin
            host_pend <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (rd_req_i) begin
            host_chan <= rd_chan_i;
        end
    end

    // single grant, and only to a source that is asking
    a_grant_onehot: assert property (
        @(posedge aclk) disable iff (rst_i)
        $onehot0(gnt_vec) && ((gnt_vec & ~req_vec) == '0)
    ) else $error("arbiter grant not one-hot or not requested");

    // host side keeps at most one read outstanding
    a_no_read_while_pending: assert property (
        @(posedge aclk) disable iff (rst_i)
        rd_req_i |-> !host_pend
    ) else $error("host read issued while previous read pending");

endmodule

/* rtl/count_ram.sv */
`timescale 1ns/1ps

module count_ram (
    input  logic                         aclk,
    input  logic                         rst_i,
    input  stat_pkg::ram_op_e            op_i,
    input  logic [stat_pkg::CHAN_W-1:0]  chan_i,
    input  logic [stat_pkg::CHUNK_W-1:0] chunk_i,
    output logic [stat_pkg::COUNT_W-1:0] rd_data_o,
    output logic                         rd_valid_o
);

    // wide per-channel totals
    logic [stat_pkg::COUNT_W-1:0] totals [stat_pkg::NUM_CHAN];
    logic [stat_pkg::COUNT_W-1:0] rd_data;
    logic                         rd_valid;

    // zero-extended chunk for the adder
    logic [stat_pkg::COUNT_W-1:0] chunk_ext;

    assign chunk_ext = stat_pkg::COUNT_W'(chunk_i);

    // read, add and write back in one cycle
    always_ff @(posedge aclk) begin
        if (rst_i) begin
            for (int i = 0; i < stat_pkg::NUM_CHAN; i++) begin
                totals[i] <= '0;
            end
        end else if (op_i == stat_pkg::OP_ACCUM) begin
            totals[chan_i] <= totals[chan_i] + chunk_ext;
        end
    end

    // host read data, registered
    // an accumulation in the same cycle cannot happen, one op per cycle
    always_ff @(posedge aclk) begin
        if (op_i == stat_pkg::OP_READ) begin
            rd_data <= totals[chan_i];
        end
    end

    always_ff @(posedge aclk) begin
        if (rst_i) begin
            rd_valid <= 1'b0;
        end else begin
            // one-cycle pulse after the read slot
            rd_valid <= (op_i == stat_pkg::OP_READ);
        end
    end

    assign rd_data_o  = rd_data;
    assign rd_valid_o = rd_valid;

    // arbiter always drives a defined command once out of reset
    a_op_known: assert property (
        @(posedge aclk) disable iff (rst_i)
        !$isunknown(op_i)
    ) else $error("count memory op is unknown");

endmodule

/* rtl/event_stat_top.sv */
`timescale 1ns/1ps

module event_stat_top (
    input  logic                          aclk,
    input  logic                          rst_i,
    input  logic [stat_pkg::NUM_CHAN-1:0] event_i,
    input  logic                          rd_req_i,
    input  logic [stat_pkg::CHAN_W-1:0]   rd_chan_i,
    output logic [stat_pkg::COUNT_W-1:0]  rd_data_o,
    output logic                          rd_valid_o
);

    // shared window tick
    logic                                              flush_tick;

    // channel side of the arbiter
    logic [stat_pkg::NUM_CHAN-1:0]                     ch_req;
    logic [stat_pkg::NUM_CHAN-1:0]                     ch_grant;
    logic [stat_pkg::NUM_CHAN-1:0][stat_pkg::CHUNK_W-1:0] ch_chunk;

    // memory command from the arbiter
    stat_pkg::ram_op_e                                 ram_op;
    logic [stat_pkg::CHAN_W-1:0]                       ram_chan;
    logic [stat_pkg::CHUNK_W-1:0]                      ram_chunk;

    flush_timer u_timer (
        .aclk         (aclk),
        .rst_i        (rst_i),
        .flush_tick_o (flush_tick)
    );

    // one narrow counter per channel
    for (genvar g = 0; g < stat_pkg::NUM_CHAN; g++) begin : g_chan
        event_chunk_counter u_chunk (
            .aclk         (aclk),
            .rst_i        (rst_i),
            .event_i      (event_i[g]),
            .flush_tick_i (flush_tick),
            .req_o        (ch_req[g]),
            .grant_i      (ch_grant[g]),
            .chunk_o      (ch_chunk[g])
        );
    end

    stat_arbiter u_arb (
        .aclk       (aclk),
        .rst_i      (rst_i),
        .ch_req_i   (ch_req),
        .ch_chunk_i (ch_chunk),
        .ch_grant_o (ch_grant),
        .rd_req_i   (rd_req_i),
        .rd_chan_i  (rd_chan_i),
        .op_o       (ram_op),
        .chan_o     (ram_chan),
        .chunk_o    (ram_chunk)
    );

    // wide totals plus host read port
    count_ram u_ram (
        .aclk       (aclk),
        .rst_i      (rst_i),
        .op_i       (ram_op),
        .chan_i     (ram_chan),
        .chunk_i    (ram_chunk),
        .rd_data_o  (rd_data_o),
        .rd_valid_o (rd_valid_o)
    );

endmodule

/* verification/event_stat_tb.sv */
`timescale 1ns/1ps

module event_stat_tb;

    localparam int RST_CYCLES     = 5;
    localparam int DRAIN_CYCLES   = 3 * stat_pkg::FLUSH_PERIOD;
    localparam int SPREAD_EVENTS  = 37;
    localparam int TRAFFIC_CYCLES = 1000;
    localparam int READ_GAP       = 20;
    localparam int SAT_WINDOWS    = 10;
    // one cycle longer than a window so host reads walk across every tick phase
    localparam int SAT_READ_GAP   = stat_pkg::FLUSH_PERIOD + 1;
    localparam int READ_LIMIT     = 16;
    // reset, spread events, traffic, saturation, drains and 16 blocking reads
    localparam int PLAN_CYCLES = RST_CYCLES + 4 * SPREAD_EVENTS + TRAFFIC_CYCLES
        + SAT_WINDOWS * stat_pkg::FLUSH_PERIOD + 3 * DRAIN_CYCLES
        + 16 * (READ_LIMIT + 2) + 200;
    localparam int MAX_CYCLES = 2 * PLAN_CYCLES;

    logic                          aclk;
    logic                          rst_i;
    logic [stat_pkg::NUM_CHAN-1:0] event_i;
    logic                          rd_req_i;
    logic [stat_pkg::CHAN_W-1:0]   rd_chan_i;
    logic [stat_pkg::COUNT_W-1:0]  rd_data_o;
    logic                          rd_valid_o;

    // events driven so far on each channel
    logic [stat_pkg::COUNT_W-1:0] ev_count [stat_pkg::NUM_CHAN];
    // last value returned by a read of each channel
    logic [stat_pkg::COUNT_W-1:0] last_rd [stat_pkg::NUM_CHAN];

    // outstanding host reads with the oldest first
    int                           q_chan [$];
    bit                           q_exact [$];
    logic [stat_pkg::COUNT_W-1:0] q_val [$];

    logic [31:0] lcg_state;
    int          val_errs;
    int          misc_errs;
    int          cycle_cnt;

    event_stat_top u_dut (
        .aclk       (aclk),
        .rst_i      (rst_i),
        .event_i    (event_i),
        .rd_req_i   (rd_req_i),
        .rd_chan_i  (rd_chan_i),
        .rd_data_o  (rd_data_o),
        .rd_valid_o (rd_valid_o)
    );

    // 8 ns clock
    always #4 aclk = ~aclk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // expected total is every event driven on the channel so far
    function automatic logic [stat_pkg::COUNT_W-1:0] ref_total(input int ch);
        return ev_count[ch];
    endfunction

    function automatic string src_name(input int ch);
        stat_pkg::src_e src;
        src = stat_pkg::src_e'(3'(ch));
        return src.name();
    endfunction

    task automatic check_total(input logic [stat_pkg::COUNT_W-1:0] got,
                               input logic [stat_pkg::COUNT_W-1:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s: got %0d, expected %0d", $time, what, got, exp);
            val_errs++;
        end
    endtask

    task automatic check_bound(input logic [stat_pkg::COUNT_W-1:0] got,
                               input logic [stat_pkg::COUNT_W-1:0] limit,
                               input string what);
        if ($isunknown(got) || got > limit) begin
            $display("[FAIL] %0t ns %s: %0d above limit %0d", $time, what, got, limit);
            val_errs++;
        end
    endtask

    // one clock of events with the reference counts following what is driven
    task automatic drive_cycle(input logic [stat_pkg::NUM_CHAN-1:0] ev);
        @(posedge aclk);
        event_i <= ev;
        for (int ch = 0; ch < stat_pkg::NUM_CHAN; ch++) begin
            if (ev[ch]) begin
                ev_count[ch]++;
            end
        end
    endtask

    task automatic drain();
        repeat (DRAIN_CYCLES) begin
            drive_cycle('0);
        end
    endtask

    // raises a host read request and queues a bound check for its data
    task automatic start_read(input int ch);
        rd_req_i  <= 1'b1;
        rd_chan_i <= stat_pkg::CHAN_W'(ch);
        q_chan.push_back(ch);
        q_exact.push_back(1'b0);
        q_val.push_back(ref_total(ch));
    endtask

    // every read posted during a phase has to be back once its drain is over
    task automatic check_reads_drained(input string phase);
        if (q_chan.size() != 0) begin
            $display("%0d reads issued during %s never returned data", q_chan.size(), phase);
            misc_errs++;
            q_chan.delete();
            q_exact.delete();
            q_val.delete();
        end
    endtask

    // blocking read whose data the compare process checks
    task automatic host_read(input int ch, input logic [stat_pkg::COUNT_W-1:0] exp);
        int wait_cyc;
        @(posedge aclk);
        rd_req_i  <= 1'b1;
        rd_chan_i <= stat_pkg::CHAN_W'(ch);
        q_chan.push_back(ch);
        q_exact.push_back(1'b1);
        q_val.push_back(exp);
        @(posedge aclk);
        rd_req_i <= 1'b0;
        wait_cyc = 0;
        do begin
            @(posedge aclk);
            wait_cyc++;
        end while (!rd_valid_o && wait_cyc < READ_LIMIT);
        if (!rd_valid_o) begin
            $display("host read of %s never returned valid data", src_name(ch));
            misc_errs++;
            q_chan.delete();
            q_exact.delete();
            q_val.delete();
        end
    endtask

    task automatic read_all();
        for (int ch = 0; ch < stat_pkg::NUM_CHAN; ch++) begin
            host_read(ch, ref_total(ch));
        end
    endtask

    // compares every returned read with what was queued at request time
    always @(posedge aclk) begin : compare_reads
        int ch;
        bit exact;
        logic [stat_pkg::COUNT_W-1:0] val;
        if (!rst_i && rd_valid_o) begin
            if (q_chan.size() == 0) begin
                $display("read valid at %0t ns with no host read outstanding", $time);
                misc_errs++;
            end else begin
                ch    = q_chan.pop_front();
                exact = q_exact.pop_front();
                val   = q_val.pop_front();
                if (exact) begin
                    check_total(rd_data_o, val, $sformatf("%s total", src_name(ch)));
                end else begin
                    // totals lag the events and never shrink
                    check_bound(rd_data_o, val,
                                $sformatf("%s read vs events", src_name(ch)));
                    check_bound(last_rd[ch], rd_data_o,
                                $sformatf("%s previous read", src_name(ch)));
                end
                last_rd[ch] = rd_data_o;
            end
        end
    end

    always @(posedge aclk) begin : watchdog
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin : run_tests
        logic [stat_pkg::NUM_CHAN-1:0] ev;
        int sent;
        aclk      = 1'b0;
        rst_i     = 1'b1;
        event_i   = '0;
        rd_req_i  = 1'b0;
        rd_chan_i = '0;
        lcg_state = 32'd72;
        val_errs  = 0;
        misc_errs = 0;
        cycle_cnt = 0;
        for (int ch = 0; ch < stat_pkg::NUM_CHAN; ch++) begin
            ev_count[ch] = '0;
            last_rd[ch]  = '0;
        end
        repeat (RST_CYCLES) @(posedge aclk);
        rst_i <= 1'b0;

        // totals start at zero
        read_all();

        // single channel with irregular spacing
        sent = 0;
        while (sent < SPREAD_EVENTS) begin
            lcg_state = lcg_step(lcg_state);
            ev        = '0;
            ev[2]     = lcg_state[28];
            drive_cycle(ev);
            if (ev[2]) begin
                sent++;
            end
        end
        drain();
        read_all();

        // random traffic on all channels with a long burst per channel
        for (int cyc = 0; cyc < TRAFFIC_CYCLES; cyc++) begin
            lcg_state = lcg_step(lcg_state);
            ev        = lcg_state[27:24];
            if ((cyc % 250) < 40) begin
                ev[2'(cyc / 250)] = 1'b1;
            end
            drive_cycle(ev);
            if (cyc % READ_GAP == READ_GAP / 2) begin
                lcg_state = lcg_step(lcg_state);
                start_read(int'(lcg_state[21:20]));
            end else begin
                rd_req_i <= 1'b0;
            end
        end
        drain();
        check_reads_drained("traffic");
        read_all();

        // every window full on every channel while host reads join as the fifth source
        for (int cyc = 0; cyc < SAT_WINDOWS * stat_pkg::FLUSH_PERIOD; cyc++) begin
            drive_cycle('1);
            if (cyc % SAT_READ_GAP == 0) begin
                lcg_state = lcg_step(lcg_state);
                start_read(int'(lcg_state[21:20]));
            end else begin
                rd_req_i <= 1'b0;
            end
        end
        drain();
        check_reads_drained("saturation");
        read_all();

        $display("errors: %0d value mismatches, %0d other failures", val_errs, misc_errs);
        if (val_errs == 0 && misc_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* build.f */
rtl/stat_pkg.sv
rtl/flush_timer.sv
rtl/event_chunk_counter.sv
rtl/stat_arbiter.sv
rtl/count_ram.sv
rtl/event_stat_top.sv
verification/event_stat_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the event statistics testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f build.f \
    --top-module event_stat_tb \
    --Mdir obj_dir \
    -o sim_event_stat \
    || { echo "verilator build failed"; exit 1; }

# keep the output in a variable so it can be shown and searched
sim_out=$(./obj_dir/sim_event_stat 2>&1)
echo "$sim_out"

echo "$sim_out" | grep -qx "RESULT: PASS" \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed"; exit 1; }
